/* common/qspi_solo_pkg.sv */
/*
 * Shared definitions for the single-lane SPI frame driver
 * Bus timing constants and field widths
 * Frame state encoding
 * Packed structs passed between the driver blocks
 */
`default_nettype none

package qspi_solo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus timing and limits
	////////////////////////////////////////////////////////////////////////////
	localparam int c_clk_ratio = 8;        // System clocks per SCK period, multiple of 4
	localparam int c_wait_ss = 4;          // SCK periods in each select guard phase
	localparam int c_max_tx_len = 262;     // Command, address and data bytes
	localparam int c_max_rx_len = 261;     // Longest read in bytes
	localparam int c_max_wait = 512;       // Dummy cycles in bit times
	localparam int c_fifo_depth_log2 = 9;  // 512 bytes per FIFO

	////////////////////////////////////////////////////////////////////////////
	// Field types
	////////////////////////////////////////////////////////////////////////////
	typedef logic [7:0] byte_t;

	// Byte counts from the host
	typedef logic [$clog2(c_max_tx_len + 1) - 1:0] tx_len_t;
	typedef logic [$clog2(c_max_rx_len + 1) - 1:0] rx_len_t;
	typedef logic [$clog2(c_max_wait + 1) - 1:0] wait_cyc_t;

	// Bit counter inside one frame phase, sized for the longest transmit
	typedef logic [$clog2(c_max_tx_len * 8 + 1) - 1:0] timer_t;

	// Position inside one SCK period
	typedef logic [$clog2(c_clk_ratio) - 1:0] phase_t;

	// Frame phases in bus order, idle first
	typedef enum logic [2:0] {
		st_idle,
		st_start_d,   // Deselect guard before select
		st_start_s,   // Select setup, CSN low, SCK parked
		st_tx,
		st_wait,      // Dummy cycles
		st_rx,
		st_stop_s,    // Select hold
		st_stop_d     // Deselect guard after release
	} spi_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Structs
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		tx_len_t tx_len;      // Bytes to shift out
		rx_len_t rx_len;      // Bytes to shift in, zero for write-only
		wait_cyc_t wait_cyc;  // Dummy SCK periods between them
	} cmd_t;

	typedef struct packed {
		logic sck;
		logic csn;   // Active low select
		logic copi;
	} spi_pins_t;

	// One-clock enables at the SCK edges
	typedef struct packed {
		logic ce_rise;  // Phase 0
		logic ce_fall;  // Phase c_clk_ratio/2
	} phase_ce_t;

endpackage

`default_nettype wire

/* rtl/sck_phase_gen.sv */
/*
 * SCK phase counter
 * Free-running count over one SCK period
 * Rise and fall clock enables, gated SCK output
 */
`timescale 1ns/100ps
`default_nettype none

module sck_phase_gen (
	input  wire logic                 i_ext_spi_clk_x,
	input  wire logic                 i_srst,
	input  wire logic                 sck_run_i,  // High in transmit, wait and receive
	output qspi_solo_pkg::phase_ce_t  ce_o,
	output logic                      sck_o
);
	import qspi_solo_pkg::*;

	phase_t phase_q;  // 0 .. c_clk_ratio-1

	// Counter runs on every clock, also while idle, so the
	// enables keep a fixed cadence for the sequencer
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			phase_q <= '0;
		end else if (phase_q == phase_t'(c_clk_ratio - 1)) begin
			phase_q <= '0;  // Wrap at end of period
		end else begin
			phase_q <= phase_q + 1'b1;
		end
	end

	assign ce_o.ce_rise = (phase_q == '0);                      // SCK goes high here
	assign ce_o.ce_fall = (phase_q == phase_t'(c_clk_ratio / 2)); // SCK low, state moves

	// High for the first half of the period, parked low otherwise
	assign sck_o = sck_run_i && (phase_q < phase_t'(c_clk_ratio / 2));

endmodule

`default_nettype wire

/* rtl/byte_fifo.sv */
/*
 * Synchronous byte FIFO with first-word-fall-through head
 * Circular buffer, read and write pointers, fill count
 * Full and empty flags, overrun and underrun ignored
 */
`timescale 1ns/100ps
`default_nettype none

module byte_fifo #(
	parameter int depth_log2 = qspi_solo_pkg::c_fifo_depth_log2
) (
	input  wire logic                  i_ext_spi_clk_x,
	input  wire logic                  i_srst,
	input  wire logic                  push_i,
	input  wire qspi_solo_pkg::byte_t  push_data_i,
	input  wire logic                  pop_i,
	output qspi_solo_pkg::byte_t       head_o,   // Oldest byte, valid when not empty
	output logic                       full_o,
	output logic                       empty_o
);
	import qspi_solo_pkg::*;

	byte_t mem [0:(1 << depth_log2) - 1];

	logic [depth_log2 - 1:0] wr_ptr_q;
	logic [depth_log2 - 1:0] rd_ptr_q;
	logic [depth_log2:0] count_q;  // One bit wider than the pointers
	logic push_ok;
	logic pop_ok;

	assign full_o  = (count_q == {1'b1, {depth_log2{1'b0}}});
	assign empty_o = (count_q == '0);

	assign push_ok = push_i && !full_o;   // Push into a full buffer is dropped
	assign pop_ok  = pop_i && !empty_o;   // Pop from an empty buffer is dropped

	// Storage, no reset needed on the data array
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (push_ok) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_ok)
				wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
			if (pop_ok)
				rd_ptr_q <= rd_ptr_q + 1'b1;

			case ({push_ok, pop_ok})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;  // Both or neither
			endcase
		end
	end

	// Fall-through read
	assign head_o = mem[rd_ptr_q];

endmodule

`default_nettype wire

/* spi_sequencer/spi_bus_sequencer.sv */
/*
 * SPI Mode 0 frame sequencer
 * Command latch and busy flag
 * Frame FSM and per-phase bit timer
 * COPI bit select, TX FIFO pops, CSN and SCK gating
 */
`timescale 1ns/100ps
`default_nettype none

module spi_bus_sequencer (
	input  wire logic                      i_ext_spi_clk_x,
	input  wire logic                      i_srst,
	input  wire logic                      go_i,
	input  wire qspi_solo_pkg::cmd_t       cmd_i,
	input  wire qspi_solo_pkg::phase_ce_t  ce_i,
	input  wire qspi_solo_pkg::byte_t      tx_byte_i,   // TX FIFO head
	input  wire logic                      tx_empty_i,
	output logic                           tx_pop_o,
	output logic                           sck_run_o,
	input  wire logic                      sck_i,
	output qspi_solo_pkg::spi_pins_t       pins_o,
	output logic                           rx_phase_o,
	output qspi_solo_pkg::timer_t          bit_idx_o,
	output logic                           idle_o
);
	import qspi_solo_pkg::*;

	spi_state_t state_q;
	spi_state_t state_nx;

	timer_t t_q;        // Bit periods spent in the current state
	timer_t t_next;
	timer_t tx_bits;
	timer_t rx_bits;
	timer_t wait_bits;

	cmd_t cmd_q;
	logic go_pend_q;    // Accepted go, waiting for the next falling edge
	logic go_accept;

	byte_t tx_byte_q;   // Byte on the wire
	logic tx_load;

	logic ss_last;
	logic tx_last;
	logic wait_last;
	logic rx_last;
	logic csn;
	logic copi;

	////////////////////////////////////////////////////////////////////////////
	// Command latch
	////////////////////////////////////////////////////////////////////////////
	assign idle_o    = (state_q == st_idle) && !go_pend_q;
	assign go_accept = go_i && idle_o;  // Go while busy is ignored

	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			go_pend_q <= 1'b0;
		end else if (go_accept) begin
			go_pend_q <= 1'b1;
		end else if (ce_i.ce_fall && (state_q == st_idle)) begin
			go_pend_q <= 1'b0;  // FSM leaves idle on this same edge
		end
	end

	always_ff @(posedge i_ext_spi_clk_x) begin
		if (go_accept)
			cmd_q <= cmd_i;
	end

	// Phase lengths in SCK periods
	assign tx_bits   = {cmd_q.tx_len, 3'b000};
	assign rx_bits   = {cmd_q.rx_len, 3'b000};
	assign wait_bits = timer_t'(cmd_q.wait_cyc);

	// Last period of a phase; a zero length still leaves after one period
	assign t_next    = t_q + 1'b1;
	assign ss_last   = (t_next >= timer_t'(c_wait_ss));
	assign tx_last   = (t_next >= tx_bits);
	assign wait_last = (t_next >= wait_bits);
	assign rx_last   = (t_next >= rx_bits);

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM, evaluated at ce_fall only
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		state_nx = state_q;
		case (state_q)
			st_idle:    if (go_pend_q) state_nx = st_start_d;
			st_start_d: if (ss_last) state_nx = st_start_s;
			st_start_s: if (ss_last) state_nx = st_tx;
			st_tx: begin
				if (tx_last) begin
					if (cmd_q.wait_cyc != '0)
						state_nx = st_wait;
					else if (cmd_q.rx_len != '0)
						state_nx = st_rx;   // No dummy cycles
					else
						state_nx = st_stop_s;  // Write only
				end
			end
			st_wait: begin
				if (wait_last)
					state_nx = (cmd_q.rx_len != '0) ? st_rx : st_stop_s;
			end
			st_rx:      if (rx_last) state_nx = st_stop_s;
			st_stop_s:  if (ss_last) state_nx = st_stop_d;
			st_stop_d:  if (ss_last) state_nx = st_idle;
		endcase
	end

	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			state_q <= st_idle;
			t_q     <= '0;
		end else if (ce_i.ce_fall) begin
			state_q <= state_nx;
			if (state_nx != state_q)
				t_q <= '0;  // Fresh count per phase
			else if (state_q != st_idle)
				t_q <= t_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// TX byte feed
	////////////////////////////////////////////////////////////////////////////
	// First byte at the end of select setup, then after each bit 7 but the last
	assign tx_load = ce_i.ce_fall &&
		(((state_q == st_start_s) && ss_last) ||
		((state_q == st_tx) && (t_q[2:0] == 3'd7) && !tx_last));
	assign tx_pop_o = tx_load && !tx_empty_i;

	// Loads the head even when empty; the byte is then undefined
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (tx_load)
			tx_byte_q <= tx_byte_i;
	end

	// Bus pins
	assign sck_run_o = (state_q == st_tx) || (state_q == st_wait) || (state_q == st_rx);
	assign csn = (state_q == st_idle) || (state_q == st_start_d) || (state_q == st_stop_d);
	assign copi = (state_q == st_tx) ? tx_byte_q[3'd7 - t_q[2:0]] : 1'b0;  // MSB first
	assign pins_o = '{sck: sck_i, csn: csn, copi: copi};

	// Shifter hooks
	assign rx_phase_o = (state_q == st_rx);
	assign bit_idx_o  = t_q;

endmodule

`default_nettype wire

/* spi_sequencer/spi_rx_shifter.sv */
/*
 * CIPO receive shifter
 * Samples at the SCK rise during the receive phase, MSB first
 * Pushes each whole byte into the RX FIFO
 */
`timescale 1ns/100ps
`default_nettype none

module spi_rx_shifter (
	input  wire logic                      i_ext_spi_clk_x,
	input  wire logic                      i_srst,
	input  wire qspi_solo_pkg::phase_ce_t  ce_i,
	input  wire logic                      rx_phase_i,
	input  wire qspi_solo_pkg::timer_t     bit_idx_i,   // Bit count inside the receive phase
	input  wire logic                      cipo_i,
	input  wire logic                      rx_full_i,
	output logic                           push_o,
	output qspi_solo_pkg::byte_t           push_data_o
);
	import qspi_solo_pkg::*;

	byte_t shift_q;
	logic push_q;
	logic sample;
	logic last_bit;

	assign sample   = ce_i.ce_rise && rx_phase_i;  // Rising SCK inside receive
	assign last_bit = (bit_idx_i[2:0] == 3'd7);    // Eighth bit of a byte

	// Shift register, payload only
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (sample)
			shift_q <= {shift_q[6:0], cipo_i};
	end

	// Push one clock after the eighth sample, dropped when RX is full
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			push_q <= 1'b0;
		end else begin
			push_q <= sample && last_bit && !rx_full_i;
		end
	end

	assign push_o      = push_q;
	assign push_data_o = shift_q;  // Complete byte while push_o is high

endmodule

`default_nettype wire

/* rtl/qspi_solo_top.sv */
/*
 * Top level of the single-lane SPI frame driver
 * Host TX and RX FIFOs, phase generator, sequencer, RX shifter
 * Registered RX data and one-clock valid strobe
 */
`timescale 1ns/100ps
`default_nettype none

module qspi_solo_top (
	input  wire logic                  i_ext_spi_clk_x,
	input  wire logic                  i_srst,
	// Frame command
	input  wire logic                  go_i,
	input  wire qspi_solo_pkg::cmd_t   cmd_i,
	// Host TX side
	input  wire qspi_solo_pkg::byte_t  tx_data_i,
	input  wire logic                  tx_enqueue_i,
	output logic                       tx_ready_o,
	// Host RX side
	input  wire logic                  rx_dequeue_i,
	output qspi_solo_pkg::byte_t       rx_data_o,
	output logic                       rx_valid_o,
	output logic                       rx_avail_o,
	output logic                       spi_idle_o,
	// SPI bus
	output qspi_solo_pkg::spi_pins_t   spi_o,
	input  wire logic                  cipo_i
);
	import qspi_solo_pkg::*;

	phase_ce_t phase_ce;
	logic sck_run;
	logic sck;

	byte_t tx_head;
	logic tx_full;
	logic tx_empty;
	logic tx_pop;

	byte_t rx_head;
	byte_t rx_push_data;
	logic rx_full;
	logic rx_empty;
	logic rx_push;

	logic rx_phase;
	timer_t bit_idx;

	logic rx_valid_q;
	byte_t rx_data_q;

	////////////////////////////////////////////////////////////////////////////
	// Host FIFOs
	////////////////////////////////////////////////////////////////////////////
	byte_fifo u_tx_fifo (
		.i_ext_spi_clk_x (i_ext_spi_clk_x),
		.i_srst          (i_srst),
		.push_i          (tx_enqueue_i),  // Ignored when full
		.push_data_i     (tx_data_i),
		.pop_i           (tx_pop),
		.head_o          (tx_head),
		.full_o          (tx_full),
		.empty_o         (tx_empty)
	);

	byte_fifo u_rx_fifo (
		.i_ext_spi_clk_x (i_ext_spi_clk_x),
		.i_srst          (i_srst),
		.push_i          (rx_push),
		.push_data_i     (rx_push_data),
		.pop_i           (rx_dequeue_i),
		.head_o          (rx_head),
		.full_o          (rx_full),
		.empty_o         (rx_empty)
	);

	assign tx_ready_o = !tx_full;
	assign rx_avail_o = !rx_empty;

	// Head is captured at the dequeue, since the pointer moves on the same edge
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (rx_dequeue_i)
			rx_data_q <= rx_head;
	end

	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst)
			rx_valid_q <= 1'b0;
		else
			rx_valid_q <= rx_dequeue_i && !rx_empty;  // One clock per byte
	end

	assign rx_data_o  = rx_data_q;
	assign rx_valid_o = rx_valid_q;

	////////////////////////////////////////////////////////////////////////////
	// Bus side
	////////////////////////////////////////////////////////////////////////////
	sck_phase_gen u_sck_phase_gen (
		.i_ext_spi_clk_x (i_ext_spi_clk_x),
		.i_srst          (i_srst),
		.sck_run_i       (sck_run),
		.ce_o            (phase_ce),
		.sck_o           (sck)
	);

	spi_bus_sequencer u_spi_bus_sequencer (
		.i_ext_spi_clk_x (i_ext_spi_clk_x),
		.i_srst          (i_srst),
		.go_i            (go_i),
		.cmd_i           (cmd_i),
		.ce_i            (phase_ce),
		.tx_byte_i       (tx_head),
		.tx_empty_i      (tx_empty),
		.tx_pop_o        (tx_pop),
		.sck_run_o       (sck_run),
		.sck_i           (sck),
		.pins_o          (spi_o),
		.rx_phase_o      (rx_phase),
		.bit_idx_o       (bit_idx),
		.idle_o          (spi_idle_o)
	);

	spi_rx_shifter u_spi_rx_shifter (
		.i_ext_spi_clk_x (i_ext_spi_clk_x),
		.i_srst          (i_srst),
		.ce_i            (phase_ce),
		.rx_phase_i      (rx_phase),
		.bit_idx_i       (bit_idx),
		.cipo_i          (cipo_i),
		.rx_full_i       (rx_full),
		.push_o          (rx_push),
		.push_data_o     (rx_push_data)
	);

endmodule

`default_nettype wire

/* verification/spi_flash_model.sv */
/*
 * SPI flash responder for the testbench
 * Records COPI bytes at the SCK rise while selected
 * Returns CIPO bytes from a table after the command and dummy bits
 */
`timescale 1ns/100ps
`default_nettype none

module spi_flash_model (
	input  wire qspi_solo_pkg::spi_pins_t  spi_i,
	input  wire qspi_solo_pkg::tx_len_t    tx_len_i,    // Command bytes in this frame
	input  wire qspi_solo_pkg::wait_cyc_t  wait_cyc_i,  // Dummy bits before the reply
	output logic                           cipo_o
);
	import qspi_solo_pkg::*;

	byte_t resp_mem [0:511];  // Reply bytes, loaded by the testbench
	byte_t cap_mem [0:511];   // COPI bytes in bus order
	int cap_cnt;
	int rise_cnt;             // SCK rises since CSN fell

	// One process watches both pins, edges found from the previous levels
	initial begin
		logic prev_sck;
		logic prev_csn;
		byte_t shift;
		int resp_start;
		int resp_bit;
		cipo_o = 1'b0;
		cap_cnt = 0;
		rise_cnt = 0;
		prev_sck = 1'b0;
		prev_csn = 1'b1;
		forever begin
			@(spi_i);
			resp_start = int'(tx_len_i) * 8 + int'(wait_cyc_i);  // First reply bit
			if (prev_csn && !spi_i.csn) begin
				cap_cnt = 0;  // New frame
				rise_cnt = 0;
				cipo_o = 1'b0;
			end else if (!spi_i.csn && !prev_sck && spi_i.sck) begin
				if (rise_cnt < int'(tx_len_i) * 8) begin
					shift = {shift[6:0], spi_i.copi};  // MSB first
					if (rise_cnt % 8 == 7) begin
						cap_mem[cap_cnt] = shift;
						cap_cnt++;
					end
				end
				rise_cnt++;
			end else if (!spi_i.csn && prev_sck && !spi_i.sck && rise_cnt >= resp_start) begin
				// Next reply bit ahead of the following rise
				resp_bit = rise_cnt - resp_start;
				cipo_o = resp_mem[resp_bit / 8][7 - resp_bit % 8];
			end
			prev_sck = spi_i.sck;
			prev_csn = spi_i.csn;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_qspi_solo.sv */
/*
 * Testbench for the single-lane SPI frame driver
 * Clock, reset, frame table and LFSR stimulus
 * Compare tasks, FIFO handshakes and the frame check loop
 */
`timescale 1ns/100ps
`default_nettype none

module tb_qspi_solo;
	import qspi_solo_pkg::*;

	localparam int c_n_frames = 5;
	localparam int c_timeout = 20000;               // Clocks allowed per wait
	localparam int c_busy_go_cyc = 100;             // Lands inside the transmit phase
	localparam logic [31:0] c_seed = 32'hbfec14ea;

	typedef struct packed {
		tx_len_t tx_len;
		wait_cyc_t wait_cyc;
		rx_len_t rx_len;
		logic [31:0] offset;  // XORed into the seed
		logic busy_go;        // Second go while the frame runs
		logic fill;           // Fill the TX FIFO to depth first
	} frame_t;

	logic clk;
	logic srst;
	logic go;
	cmd_t cmd;
	byte_t tx_data;
	logic tx_enqueue;
	logic tx_ready;
	logic rx_dequeue;
	byte_t rx_data;
	logic rx_valid;
	logic rx_avail;
	logic spi_idle;
	spi_pins_t spi;
	logic cipo;

	tx_len_t model_tx_len;
	wait_cyc_t model_wait_cyc;

	frame_t frames [0:c_n_frames - 1];
	string frame_name [0:c_n_frames - 1];
	byte_t exp_tx [0:511];   // Bytes expected on COPI
	byte_t exp_rx [0:511];   // Bytes expected from the RX FIFO
	logic [31:0] lfsr_q;

	qspi_solo_top qspi_solo_top_i (
		.i_ext_spi_clk_x (clk),
		.i_srst          (srst),
		.go_i            (go),
		.cmd_i           (cmd),
		.tx_data_i       (tx_data),
		.tx_enqueue_i    (tx_enqueue),
		.tx_ready_o      (tx_ready),
		.rx_dequeue_i    (rx_dequeue),
		.rx_data_o       (rx_data),
		.rx_valid_o      (rx_valid),
		.rx_avail_o      (rx_avail),
		.spi_idle_o      (spi_idle),
		.spi_o           (spi),
		.cipo_i          (cipo)
	);

	spi_flash_model u_flash_model (
		.spi_i      (spi),
		.tx_len_i   (model_tx_len),
		.wait_cyc_i (model_wait_cyc),
		.cipo_o     (cipo)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;  // 4 ns period

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////
	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_byte(output byte_t b);
		b = '0;
		for (int k = 0; k < 8; k++) begin
			b = {b[6:0], lfsr_q[0]};  // One step per bit
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic stop_on_failure();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic timeout_abort(input string what);
		$display("Timeout while waiting: %s", what);
		stop_on_failure();
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_count(input string name, input timer_t exp, input timer_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic enqueue_byte(input byte_t b);
		@(posedge clk);
		tx_data <= b;
		tx_enqueue <= 1'b1;
		@(posedge clk);
		tx_enqueue <= 1'b0;
	endtask

	// Go pulse, then watch the bus each clock until the driver is idle
	task automatic run_until_idle(input string name, input cmd_t c, input logic busy_go,
			output timer_t csn_falls);
		cmd_t busy_cmd;
		logic csn_prev;
		int cyc;
		busy_cmd = c;
		busy_cmd.tx_len = c.tx_len + 3'd3;  // Differs in every field
		busy_cmd.rx_len = c.rx_len + 1'b1;
		busy_cmd.wait_cyc = c.wait_cyc + 2'd2;
		@(posedge clk);
		go <= 1'b1;
		cmd <= c;
		@(posedge clk);
		go <= 1'b0;
		@(negedge clk);
		check_flag($sformatf("%s idle after go", name), 1'b0, spi_idle);
		csn_prev = spi.csn;
		csn_falls = '0;
		cyc = 0;
		while (!spi_idle && cyc < c_timeout) begin
			@(posedge clk);
			go <= busy_go && (cyc == c_busy_go_cyc);
			cmd <= (cyc == c_busy_go_cyc) ? busy_cmd : c;
			@(negedge clk);
			if (csn_prev && !spi.csn)
				csn_falls = csn_falls + 1'b1;
			csn_prev = spi.csn;
			cyc++;
		end
		if (!spi_idle)
			timeout_abort("frame never returned to idle");
	endtask

	// One dequeue with valid and data one clock later
	task automatic dequeue_and_check(input string name, input byte_t exp, input logic last);
		int cyc;
		cyc = 0;
		while (!rx_avail && cyc < c_timeout) begin
			@(negedge clk);
			cyc++;
		end
		if (!rx_avail)
			timeout_abort("RX FIFO stayed empty");
		@(posedge clk);
		rx_dequeue <= 1'b1;
		@(negedge clk);
		check_flag($sformatf("%s rx_valid early", name), 1'b0, rx_valid);
		@(posedge clk);
		rx_dequeue <= 1'b0;
		@(negedge clk);
		check_flag($sformatf("%s rx_valid", name), 1'b1, rx_valid);
		check_byte(name, exp, rx_data);
		if (last)
			check_flag($sformatf("%s rx_avail after last", name), 1'b0, rx_avail);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Frame table and check loop
	////////////////////////////////////////////////////////////////////////////
	initial begin
		frame_t f;
		string name;
		byte_t b;
		cmd_t c;
		timer_t csn_falls;
		int n_fill;
		srst = 1'b1;
		go = 1'b0;
		cmd = '0;
		tx_data = '0;
		tx_enqueue = 1'b0;
		rx_dequeue = 1'b0;
		model_tx_len = '0;
		model_wait_cyc = '0;
		// tx_len, wait_cyc, rx_len, seed offset, busy go, fill
		frames[0] = {tx_len_t'(4), wait_cyc_t'(0), rx_len_t'(0), 32'h0000_0001, 1'b0, 1'b0};
		frames[1] = {tx_len_t'(4), wait_cyc_t'(8), rx_len_t'(6), 32'h0000_0a02, 1'b0, 1'b0};
		frames[2] = {tx_len_t'(1), wait_cyc_t'(0), rx_len_t'(3), 32'h0031_0003, 1'b0, 1'b0};
		frames[3] = {tx_len_t'(5), wait_cyc_t'(3), rx_len_t'(2), 32'h4400_0004, 1'b1, 1'b0};
		frames[4] = {tx_len_t'(6), wait_cyc_t'(0), rx_len_t'(0), 32'h0000_5505, 1'b0, 1'b1};
		frame_name[0] = "write_only";
		frame_name[1] = "read_dummy";
		frame_name[2] = "read_no_dummy";
		frame_name[3] = "busy_go";
		frame_name[4] = "tx_fifo_fill";

		repeat (8) @(posedge clk);
		srst <= 1'b0;

		for (int n = 0; n < c_n_frames; n++) begin
			f = frames[n];
			name = frame_name[n];
			lfsr_q = c_seed ^ f.offset;
			n_fill = f.fill ? (1 << c_fifo_depth_log2) : int'(f.tx_len);
			for (int i = 0; i < n_fill; i++) begin
				draw_byte(b);
				exp_tx[i] = b;
				@(negedge clk);
				check_flag($sformatf("%s tx_ready before byte %0d", name, i), 1'b1, tx_ready);
				enqueue_byte(b);
			end
			if (f.fill) begin
				@(negedge clk);
				check_flag($sformatf("%s tx_ready at depth", name), 1'b0, tx_ready);
				enqueue_byte(~exp_tx[0]);  // Must be dropped
				@(negedge clk);
				check_flag($sformatf("%s tx_ready after extra", name), 1'b0, tx_ready);
			end
			for (int i = 0; i < int'(f.rx_len); i++) begin
				draw_byte(b);
				exp_rx[i] = b;
				u_flash_model.resp_mem[i] = b;
			end
			model_tx_len = f.tx_len;
			model_wait_cyc = f.wait_cyc;
			c.tx_len = f.tx_len;
			c.rx_len = f.rx_len;
			c.wait_cyc = f.wait_cyc;
			run_until_idle(name, c, f.busy_go, csn_falls);

			// Bus shape of the finished frame
			check_flag($sformatf("%s csn at idle", name), 1'b1, spi.csn);
			check_count($sformatf("%s csn low intervals", name), timer_t'(1), csn_falls);
			check_count($sformatf("%s sck rises", name),
				timer_t'(8 * f.tx_len + f.wait_cyc + 8 * f.rx_len),
				timer_t'(u_flash_model.rise_cnt));
			check_count($sformatf("%s copi bytes", name), timer_t'(f.tx_len),
				timer_t'(u_flash_model.cap_cnt));
			for (int i = 0; i < int'(f.tx_len); i++)
				check_byte($sformatf("%s copi byte %0d", name, i), exp_tx[i],
					u_flash_model.cap_mem[i]);

			// Returned bytes from the RX FIFO
			for (int i = 0; i < int'(f.rx_len); i++)
				dequeue_and_check($sformatf("%s rx byte %0d", name, i), exp_rx[i],
					i == int'(f.rx_len) - 1);
			if (f.rx_len == '0)
				check_flag($sformatf("%s rx_avail", name), 1'b0, rx_avail);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
common/qspi_solo_pkg.sv
rtl/sck_phase_gen.sv
rtl/byte_fifo.sv
spi_sequencer/spi_bus_sequencer.sv
spi_sequencer/spi_rx_shifter.sv
rtl/qspi_solo_top.sv
verification/spi_flash_model.sv
verification/tb_qspi_solo.sv

/* Bender.yml */
package:
  name: qspi_solo

sources:
  # Shared package first
  - common/qspi_solo_pkg.sv
  # Design
  - rtl/sck_phase_gen.sv
  - rtl/byte_fifo.sv
  - spi_sequencer/spi_bus_sequencer.sv
  - spi_sequencer/spi_rx_shifter.sv
  - rtl/qspi_solo_top.sv
  # Testbench
  - target: simulation
    files:
      - verification/spi_flash_model.sv
      - verification/tb_qspi_solo.sv
